// ==== hdl/coh_config.svh ====
`ifndef COH_CONFIG_SVH
`define COH_CONFIG_SVH

// Lines per private cache of one word each
`define COH_NUM_LINES 4

// Shared memory depth in words
`define COH_MEM_WORDS 64

// Cycles from memory request to ack
`define COH_MEM_LATENCY 2

`endif

// ==== hdl/coh_pkg.sv ====
`default_nettype none
`include "coh_config.svh"

package coh_pkg;

    localparam int IDX_W  = $clog2(`COH_NUM_LINES);  // Cache index bits
    localparam int MEM_AW = $clog2(`COH_MEM_WORDS);  // Memory word index bits

    typedef logic [31:0]           word_t;
    typedef logic [31:0]           addr_t;     // Byte address
    typedef logic [IDX_W-1:0]      idx_t;
    typedef logic [31-IDX_W-2:0]   tag_t;      // Bits above index
    typedef logic [MEM_AW-1:0]     mem_idx_t;

    typedef enum logic [1:0] {
        M_INVALID  = 2'd0,
        M_SHARED   = 2'd1,
        M_MODIFIED = 2'd2
    } msi_state_e;

    typedef enum logic [1:0] {
        BUS_RD  = 2'd0,  // Read for sharing
        BUS_RDX = 2'd1,  // Read for ownership
        BUS_WB  = 2'd2   // Victim write-back
    } bus_op_e;

    typedef enum logic [1:0] {
        C_IDLE,
        C_WB,
        C_FILL,
        C_DONE
    } cache_fsm_e;

    typedef enum logic [1:0] {
        B_IDLE,
        B_SNOOP,
        B_MEM,
        B_RESP
    } bus_fsm_e;

    typedef struct packed {
        addr_t addr;
        word_t wdata;
        logic  ren;
        logic  wen;
    } proc_req_t;

    typedef struct packed {
        word_t rdata;
        logic  busy;
    } proc_rsp_t;

    typedef struct packed {
        logic    valid;
        bus_op_e op;
        addr_t   addr;
        word_t   wdata;
    } bus_req_t;

    typedef struct packed {
        logic  done;
        word_t rdata;
    } bus_rsp_t;

    typedef struct packed {
        logic    valid;
        bus_op_e op;
        addr_t   addr;
    } snoop_req_t;

    typedef struct packed {
        logic  dirty;  // Line was held Modified
        word_t data;
    } snoop_rsp_t;

    typedef struct packed {
        logic  valid;
        logic  we;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  ack;
        word_t rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

// ==== hdl/l1_cache.sv ====
`default_nettype none
`include "coh_config.svh"

module l1_cache (
    input  logic                CLK,
    input  logic                arst_n,
    input  coh_pkg::proc_req_t  proc_req,
    output coh_pkg::proc_rsp_t  proc_rsp,
    output coh_pkg::bus_req_t   bus_req,
    input  coh_pkg::bus_rsp_t   bus_rsp,
    input  coh_pkg::snoop_req_t snoop_req,
    output coh_pkg::snoop_rsp_t snoop_rsp
);

    coh_pkg::tag_t       tags  [`COH_NUM_LINES];
    coh_pkg::word_t      data  [`COH_NUM_LINES];
    coh_pkg::msi_state_e state [`COH_NUM_LINES];

    coh_pkg::cache_fsm_e fsm_q;
    coh_pkg::cache_fsm_e fsm_d;

    coh_pkg::idx_t idx;
    coh_pkg::tag_t tag;
    coh_pkg::idx_t sidx;
    coh_pkg::tag_t stag;

    logic req;
    logic tag_hit;
    logic read_hit;
    logic write_hit;
    logic hit_ok;
    logic snoop_hit;
    logic conflict;

    assign idx  = proc_req.addr[2 +: coh_pkg::IDX_W];
    assign tag  = proc_req.addr[31:2+coh_pkg::IDX_W];
    assign sidx = snoop_req.addr[2 +: coh_pkg::IDX_W];
    assign stag = snoop_req.addr[31:2+coh_pkg::IDX_W];

    assign req       = proc_req.ren | proc_req.wen;
    assign tag_hit   = (state[idx] != coh_pkg::M_INVALID) && (tags[idx] == tag);
    assign read_hit  = proc_req.ren && tag_hit;
    assign write_hit = proc_req.wen && tag_hit && (state[idx] == coh_pkg::M_MODIFIED);

    assign snoop_hit = snoop_req.valid && (state[sidx] != coh_pkg::M_INVALID)
                       && (tags[sidx] == stag);
    assign conflict  = snoop_hit && (sidx == idx);  // Core retries next cycle
    assign hit_ok    = (fsm_q == coh_pkg::C_IDLE) && (read_hit || write_hit) && !conflict;

    always_comb begin
        snoop_rsp.dirty = snoop_hit && (state[sidx] == coh_pkg::M_MODIFIED);
        snoop_rsp.data  = data[sidx];
    end

    always_comb begin
        proc_rsp.rdata = data[idx];
        proc_rsp.busy  = req && !hit_ok && (fsm_q != coh_pkg::C_DONE);
    end

    always_comb begin
        fsm_d   = fsm_q;
        bus_req = '0;
        case (fsm_q)
            coh_pkg::C_IDLE: begin
                if (req && !conflict && !read_hit && !write_hit) begin
                    // A Modified line here must belong to another tag
                    if (state[idx] == coh_pkg::M_MODIFIED) begin
                        fsm_d = coh_pkg::C_WB;
                    end else begin
                        fsm_d = coh_pkg::C_FILL;
                    end
                end
            end
            coh_pkg::C_WB: begin
                bus_req.valid = 1'b1;
                bus_req.op    = coh_pkg::BUS_WB;
                bus_req.addr  = {tags[idx], idx, 2'b00};  // Victim address
                bus_req.wdata = data[idx];
                if (bus_rsp.done) begin
                    fsm_d = coh_pkg::C_FILL;
                end
            end
            coh_pkg::C_FILL: begin
                bus_req.valid = 1'b1;
                bus_req.op    = proc_req.wen ? coh_pkg::BUS_RDX : coh_pkg::BUS_RD;
                bus_req.addr  = proc_req.addr;
                bus_req.wdata = proc_req.wdata;
                if (bus_rsp.done) begin
                    fsm_d = coh_pkg::C_DONE;
                end
            end
            default: begin
                fsm_d = coh_pkg::C_IDLE;  // Core sees busy low here
            end
        endcase
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            fsm_q <= coh_pkg::C_IDLE;
            for (int i = 0; i < `COH_NUM_LINES; i++) begin
                state[i] <= coh_pkg::M_INVALID;
            end
        end else begin
            fsm_q <= fsm_d;
            if (fsm_q == coh_pkg::C_WB && bus_rsp.done) begin
                state[idx] <= coh_pkg::M_INVALID;
            end
            if (fsm_q == coh_pkg::C_FILL && bus_rsp.done) begin
                state[idx] <= proc_req.wen ? coh_pkg::M_MODIFIED : coh_pkg::M_SHARED;
            end
            // Snoop update comes last so it wins
            if (snoop_hit) begin
                if (snoop_req.op == coh_pkg::BUS_RDX) begin
                    state[sidx] <= coh_pkg::M_INVALID;
                end else if (state[sidx] == coh_pkg::M_MODIFIED) begin
                    state[sidx] <= coh_pkg::M_SHARED;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (hit_ok && proc_req.wen) begin
            data[idx] <= proc_req.wdata;
        end
        if (fsm_q == coh_pkg::C_FILL && bus_rsp.done) begin
            tags[idx] <= tag;
            data[idx] <= proc_req.wen ? proc_req.wdata : bus_rsp.rdata;  // Merge write
        end
    end

endmodule

`default_nettype wire

// ==== hdl/bus_ctrl.sv ====
`default_nettype none

module bus_ctrl (
    input  logic                CLK,
    input  logic                arst_n,
    input  coh_pkg::bus_req_t   c0_req,
    output coh_pkg::bus_rsp_t   c0_rsp,
    input  coh_pkg::bus_req_t   c1_req,
    output coh_pkg::bus_rsp_t   c1_rsp,
    output coh_pkg::snoop_req_t c0_snoop,
    input  coh_pkg::snoop_rsp_t c0_snoop_rsp,
    output coh_pkg::snoop_req_t c1_snoop,
    input  coh_pkg::snoop_rsp_t c1_snoop_rsp,
    output coh_pkg::mem_req_t   mem_req,
    input  coh_pkg::mem_rsp_t   mem_rsp
);

    coh_pkg::bus_fsm_e state_q;
    logic              grant_q;      // Owner of the current transaction
    logic              prio_q;       // Winner on a tie
    logic              snp_dirty_q;
    coh_pkg::word_t    snp_data_q;
    coh_pkg::word_t    rdata_q;

    logic                grant_d;
    coh_pkg::bus_req_t   pick_req;
    coh_pkg::bus_req_t   cur_req;
    coh_pkg::snoop_rsp_t cur_snp;
    logic                is_wb;

    assign grant_d  = (c0_req.valid && c1_req.valid) ? prio_q : c1_req.valid;
    assign pick_req = grant_d ? c1_req : c0_req;
    assign cur_req  = grant_q ? c1_req : c0_req;
    assign cur_snp  = grant_q ? c0_snoop_rsp : c1_snoop_rsp;  // Answer of the other cache
    assign is_wb    = (cur_req.op == coh_pkg::BUS_WB);

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            state_q     <= coh_pkg::B_IDLE;
            grant_q     <= 1'b0;
            prio_q      <= 1'b0;
            snp_dirty_q <= 1'b0;
        end else begin
            case (state_q)
                coh_pkg::B_IDLE: begin
                    if (c0_req.valid || c1_req.valid) begin
                        grant_q     <= grant_d;
                        prio_q      <= ~grant_d;
                        snp_dirty_q <= 1'b0;
                        if (pick_req.op == coh_pkg::BUS_WB) begin
                            state_q <= coh_pkg::B_MEM;  // Write-back skips the snoop
                        end else begin
                            state_q <= coh_pkg::B_SNOOP;
                        end
                    end
                end
                coh_pkg::B_SNOOP: begin
                    snp_dirty_q <= cur_snp.dirty;
                    state_q     <= coh_pkg::B_MEM;
                end
                coh_pkg::B_MEM: begin
                    if (mem_rsp.ack) begin
                        state_q <= coh_pkg::B_RESP;
                    end
                end
                default: begin
                    state_q <= coh_pkg::B_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state_q == coh_pkg::B_SNOOP) begin
            snp_data_q <= cur_snp.data;
        end
        if (state_q == coh_pkg::B_MEM && mem_rsp.ack) begin
            rdata_q <= snp_dirty_q ? snp_data_q : mem_rsp.rdata;  // Owner data first
        end
    end

    always_comb begin
        c0_rsp.done  = (state_q == coh_pkg::B_RESP) && !grant_q;
        c0_rsp.rdata = rdata_q;
        c1_rsp.done  = (state_q == coh_pkg::B_RESP) && grant_q;
        c1_rsp.rdata = rdata_q;

        c0_snoop.valid = (state_q == coh_pkg::B_SNOOP) && grant_q;
        c0_snoop.op    = cur_req.op;
        c0_snoop.addr  = cur_req.addr;
        c1_snoop.valid = (state_q == coh_pkg::B_SNOOP) && !grant_q;
        c1_snoop.op    = cur_req.op;
        c1_snoop.addr  = cur_req.addr;

        // Dirty snoop data is written through to memory
        mem_req.valid = (state_q == coh_pkg::B_MEM);
        mem_req.we    = is_wb || snp_dirty_q;
        mem_req.addr  = cur_req.addr;
        mem_req.wdata = is_wb ? cur_req.wdata : snp_data_q;
    end

endmodule

`default_nettype wire

// ==== hdl/main_mem.sv ====
`default_nettype none
`include "coh_config.svh"

module main_mem (
    input  logic              CLK,
    input  logic              arst_n,
    input  coh_pkg::mem_req_t mem_req,
    output coh_pkg::mem_rsp_t mem_rsp
);

    localparam int LAT_W = $clog2(`COH_MEM_LATENCY + 1);

    coh_pkg::word_t    mem [`COH_MEM_WORDS];
    logic [LAT_W-1:0]  cnt_q;  // Zero when idle
    coh_pkg::mem_idx_t widx;
    logic              ack;

    assign widx = mem_req.addr[2 +: coh_pkg::MEM_AW];  // Word address wraps
    assign ack  = (cnt_q == LAT_W'(1));

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            cnt_q <= '0;
            for (int i = 0; i < `COH_MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (cnt_q != '0) begin
                cnt_q <= cnt_q - LAT_W'(1);
            end else if (mem_req.valid) begin
                cnt_q <= LAT_W'(`COH_MEM_LATENCY);
            end
            if (ack && mem_req.we) begin
                mem[widx] <= mem_req.wdata;  // Write lands with the ack
            end
        end
    end

    always_comb begin
        mem_rsp.ack   = ack;
        mem_rsp.rdata = mem[widx];
    end

endmodule

`default_nettype wire

// ==== hdl/two_cache_coh.sv ====
`default_nettype none

module two_cache_coh (
    input  logic               CLK,
    input  logic               arst_n,
    input  coh_pkg::proc_req_t core0_req,
    output coh_pkg::proc_rsp_t core0_rsp,
    input  coh_pkg::proc_req_t core1_req,
    output coh_pkg::proc_rsp_t core1_rsp
);

    coh_pkg::bus_req_t   c0_bus_req;
    coh_pkg::bus_rsp_t   c0_bus_rsp;
    coh_pkg::bus_req_t   c1_bus_req;
    coh_pkg::bus_rsp_t   c1_bus_rsp;
    coh_pkg::snoop_req_t c0_snoop;
    coh_pkg::snoop_rsp_t c0_snoop_rsp;
    coh_pkg::snoop_req_t c1_snoop;
    coh_pkg::snoop_rsp_t c1_snoop_rsp;
    coh_pkg::mem_req_t   mem_req;
    coh_pkg::mem_rsp_t   mem_rsp;

    l1_cache cache0 (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .proc_req  (core0_req),
        .proc_rsp  (core0_rsp),
        .bus_req   (c0_bus_req),
        .bus_rsp   (c0_bus_rsp),
        .snoop_req (c0_snoop),
        .snoop_rsp (c0_snoop_rsp)
    );

    l1_cache cache1 (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .proc_req  (core1_req),
        .proc_rsp  (core1_rsp),
        .bus_req   (c1_bus_req),
        .bus_rsp   (c1_bus_rsp),
        .snoop_req (c1_snoop),
        .snoop_rsp (c1_snoop_rsp)
    );

    bus_ctrl bus0 (
        .CLK          (CLK),
        .arst_n       (arst_n),
        .c0_req       (c0_bus_req),
        .c0_rsp       (c0_bus_rsp),
        .c1_req       (c1_bus_req),
        .c1_rsp       (c1_bus_rsp),
        .c0_snoop     (c0_snoop),
        .c0_snoop_rsp (c0_snoop_rsp),
        .c1_snoop     (c1_snoop),
        .c1_snoop_rsp (c1_snoop_rsp),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp)
    );

    main_mem mem0 (
        .CLK     (CLK),
        .arst_n  (arst_n),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
    output logic CLK
);

    initial begin
        CLK = 1'b0;
    end

    always #20 CLK = ~CLK;  // 40-unit period

endmodule

`default_nettype wire

// ==== dv/tb_two_cache_coh.sv ====
`default_nettype none

module tb_two_cache_coh;

    logic               CLK;
    logic               arst_n;
    coh_pkg::proc_req_t core0_req;
    coh_pkg::proc_rsp_t core0_rsp;
    coh_pkg::proc_req_t core1_req;
    coh_pkg::proc_rsp_t core1_rsp;

    // One entry per golden line
    int             test_q  [$];
    int             core_q  [$];
    logic           write_q [$];
    coh_pkg::addr_t addr_q  [$];
    coh_pkg::word_t wdata_q [$];
    coh_pkg::word_t exp_q   [$];

    int err_count;
    int tests_passed;
    int tests_failed;
    int cycle_cnt;
    int cycle_limit;  // Zero until the golden file is loaded

    tb_clock_gen clk0 (.CLK(CLK));

    two_cache_coh dut0 (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .core0_req (core0_req),
        .core0_rsp (core0_rsp),
        .core1_req (core1_req),
        .core1_rsp (core1_rsp)
    );

    task automatic load_golden(output logic loaded);
        int             fd;
        int             rc;
        int             n_test;
        int             n_core;
        logic [7:0]     op_chr;
        coh_pkg::addr_t addr;
        coh_pkg::word_t wdata;
        coh_pkg::word_t expected;
        string          line;
        loaded = 1'b0;
        fd = $fopen("dv/coh_golden.txt", "r");
        if (fd != 0) begin
            loaded = 1'b1;
            while (!$feof(fd)) begin
                rc = $fgets(line, fd);
                if (rc == 0) begin
                    break;
                end
                if (line.getc(0) != "#") begin
                    rc = $sscanf(line, "%d %d %s %h %h %h", n_test, n_core, op_chr,
                                 addr, wdata, expected);
                    if (rc == 6) begin
                        test_q.push_back(n_test);
                        core_q.push_back(n_core);
                        write_q.push_back(op_chr == "W");
                        addr_q.push_back(addr);
                        wdata_q.push_back(wdata);
                        exp_q.push_back(expected);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic set_core_req(input int core, input coh_pkg::proc_req_t req);
        if (core == 1) begin
            core1_req = req;
        end else begin
            core0_req = req;
        end
    endtask

    // Holds the request until busy is seen low, as a core would
    task automatic run_access(input int core, input logic is_write, input coh_pkg::addr_t addr,
                              input coh_pkg::word_t wdata, output coh_pkg::word_t rdata);
        coh_pkg::proc_req_t req;
        logic               busy;
        req.addr  = addr;
        req.wdata = wdata;
        req.ren   = !is_write;
        req.wen   = is_write;
        @(posedge CLK);
        #2;
        set_core_req(core, req);
        busy = 1'b1;
        while (busy) begin
            @(negedge CLK);  // Outputs settled by mid-cycle
            busy  = (core == 1) ? core1_rsp.busy : core0_rsp.busy;
            rdata = (core == 1) ? core1_rsp.rdata : core0_rsp.rdata;
        end
        @(posedge CLK);
        #2;
        set_core_req(core, '0);
    endtask

    task automatic check_word(input coh_pkg::word_t actual, input coh_pkg::word_t expected,
                              input coh_pkg::addr_t addr);
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0t: read of address %h returned %h, expected %h",
                     $time, addr, actual, expected);
            err_count++;
        end
    endtask

    task automatic report_test(input int num, input int errs);
        if (errs == 0) begin
            tests_passed++;
            $display("test %0d passed", num);
        end else begin
            tests_failed++;
            $display("test %0d failed with %0d errors", num, errs);
        end
    endtask

    always @(posedge CLK) begin
        cycle_cnt++;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        int             err_base;
        logic           loaded;
        coh_pkg::word_t rdata;
        core0_req    = '0;
        core1_req    = '0;
        arst_n       = 1'b0;
        err_count    = 0;
        err_base     = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycle_cnt    = 0;
        cycle_limit  = 0;
        load_golden(loaded);
        if (!loaded) begin
            $display("Could not open dv/coh_golden.txt for reading");
            $display(">>> FAIL");
            $finish;
        end else begin
            cycle_limit = 8 + 40 * test_q.size();  // Reset plus worst-case access
            repeat (8) @(posedge CLK);
            #2;
            arst_n = 1'b1;
            for (int i = 0; i < test_q.size(); i++) begin
                if (i > 0 && test_q[i] != test_q[i-1]) begin
                    report_test(test_q[i-1], err_count - err_base);
                    err_base = err_count;
                end
                run_access(core_q[i], write_q[i], addr_q[i], wdata_q[i], rdata);
                if (!write_q[i]) begin
                    check_word(rdata, exp_q[i], addr_q[i]);
                end
            end
            if (test_q.size() > 0) begin
                report_test(test_q[test_q.size()-1], err_count - err_base);
            end
            $display("summary: %0d tests passed, %0d tests failed, %0d check errors",
                     tests_passed, tests_failed, err_count);
            if (tests_failed == 0 && tests_passed > 0) begin
                $display(">>> PASS");
            end else begin
                $display(">>> FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== dv/coh_golden.txt ====
# test core op addr wdata expected (hex fields, op is R or W)
# expected read data is checked on R lines only
1 0 R 00000000 00000000 00000000
1 1 R 00000004 00000000 00000000
1 0 R 00000008 00000000 00000000
1 1 R 0000000c 00000000 00000000
2 0 W 00000010 a1b2c3d4 00000000
2 1 R 00000010 00000000 a1b2c3d4
2 0 R 00000010 00000000 a1b2c3d4
3 0 R 00000024 00000000 00000000
3 1 R 00000024 00000000 00000000
3 1 W 00000024 5eed0003 00000000
3 0 R 00000024 00000000 5eed0003
4 0 W 00000038 cafe0038 00000000
4 0 W 00000048 beef0048 00000000
4 1 R 00000038 00000000 cafe0038
4 0 R 00000048 00000000 beef0048
5 0 W 0000002c 11111111 00000000
5 1 R 0000002c 00000000 11111111
5 1 W 0000002c 22222222 00000000
5 0 R 0000002c 00000000 22222222
5 0 W 0000002c 33333333 00000000
5 1 R 0000002c 00000000 33333333

// ==== filelist.f ====
+incdir+hdl
hdl/coh_pkg.sv
hdl/l1_cache.sv
hdl/bus_ctrl.sv
hdl/main_mem.sv
hdl/two_cache_coh.sv
dv/tb_clock_gen.sv
dv/tb_two_cache_coh.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the two-cache coherence testbench with Verilator
rm -f sim.log
verilator --binary --timing --top-module tb_two_cache_coh -f filelist.f \
    -o sim_two_cache_coh > build.log 2>&1 \
    && ./obj_dir/sim_two_cache_coh > sim.log 2>&1
grep -q '^>>> PASS$' sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
